//--- tb.f
common/alert_cfg_pkg.sv
common/alert_types_pkg.sv
lfsr_bank/lfsr_bank.sv
design/fault_classifier.sv
design/alert_queue.sv
design/alert_reporter.sv
design/alert_csr.sv
design/xsecure_alerts_top.sv
bench/tb_xsecure_alerts.sv

//--- run.sh
#!/bin/sh
# Build and run the alert subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_xsecure_alerts -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "Simulation finished: PASS" sim.log \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }

//--- bench/tb_xsecure_alerts.sv
`timescale 1ns/1ps
// ----------------------------------------------------------
// Testbench for the security alert subsystem
// Exception filter, seed lockup, NMI path, overflow, registers
// ----------------------------------------------------------
module tb_xsecure_alerts;
  import alert_cfg_pkg::*;
  import alert_types_pkg::*;

  // About 400 cycles of tests, generous margin
  localparam int MAX_CYCLES = 3000;
  localparam int BURST_WRITES = 20;
  localparam int BURST_RETIRES = 40;

  logic        clk_i = 1'b0;
  logic        reset_i;
  wbs_req_t    wbs_req;
  wbs_rsp_t    wbs_rsp;
  wb_retire_t  retire;
  dbus_resp_t  dbus;
  logic        dummy_en;
  logic        hint_en;
  logic        nmi_ack;
  logic        alert_minor;
  logic        nmip;

  int          cycle_cnt = 0;
  int unsigned seen_alerts = 0;
  int unsigned model_alerts;
  logic [31:0] rng;
  logic [31:0] rdata;
  logic [31:0] seeds [3];
  int          pick;
  int          count_before;
  int          burst_events;
  // Alert-worthy causes 1, 2, 5, 7, 24
  logic [CAUSE_WIDTH-1:0] alert_causes [5] = '{11'd1, 11'd2, 11'd5, 11'd7, 11'd24};

  xsecure_alerts_top i_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wbs_req_i     (wbs_req),
    .wbs_rsp_o     (wbs_rsp),
    .retire_i      (retire),
    .dbus_i        (dbus),
    .dummy_en_i    (dummy_en),
    .hint_en_i     (hint_en),
    .nmi_ack_i     (nmi_ack),
    .alert_minor_o (alert_minor),
    .nmip_o        (nmip)
  );

  always #2 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_error(input string msg);
    $display("Error: time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else report_error($sformatf("%s: got 0x%08h, expected 0x%08h", what, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic is_alert_cause(input logic [CAUSE_WIDTH-1:0] cause);
    logic hit;
    hit = 1'b0;
    foreach (alert_causes[k]) begin
      if (alert_causes[k] == cause) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Run length limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles without finishing", MAX_CYCLES);
      abort_run();
    end
  end

  // One count per high cycle of the minor alert
  always @(posedge clk_i) begin
    if (!reset_i && alert_minor) begin
      seen_alerts <= seen_alerts + 1;
    end
  end

  // Ack is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (reset_i) wbs_rsp.ack |=> !wbs_rsp.ack)
    else report_error("ack stayed high for more than one cycle");

  // Outputs quiet out of reset
  assert property (@(posedge clk_i) reset_i |=> (!alert_minor && !nmip && !wbs_rsp.ack))
    else report_error("output active right after reset");

  // Master side of a classic Wishbone cycle
  task automatic wb_access(input logic we, input logic [ADDR_WIDTH-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rd);
    int waited;
    waited = 0;
    // Previous ack must be gone first
    while (wbs_rsp.ack) @(negedge clk_i);
    wbs_req.cyc = 1'b1;
    wbs_req.stb = 1'b1;
    wbs_req.we  = we;
    wbs_req.adr = adr;
    wbs_req.dat = wdata;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!wbs_rsp.ack);
    rd = wbs_rsp.dat;
    wbs_req.cyc = 1'b0;
    wbs_req.stb = 1'b0;
    wbs_req.we  = 1'b0;
    assert (waited == 1)
      else report_error($sformatf("ack came %0d cycles after the request", waited));
  endtask

  task automatic wb_write(input logic [ADDR_WIDTH-1:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input logic [ADDR_WIDTH-1:0] adr, output logic [31:0] rd);
    wb_access(1'b0, adr, 32'd0, rd);
  endtask

  // Wait for the expected alerts, then make sure no extra ones follow
  task automatic wait_alerts(input int unsigned expected);
    while (seen_alerts < expected) @(negedge clk_i);
    repeat (QUEUE_DEPTH + 4) @(negedge clk_i);
    assert (seen_alerts == expected)
      else report_error($sformatf("saw %0d alerts, expected %0d", seen_alerts, expected));
  endtask

  // Queue drained once the alert stays low for a few cycles
  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      @(negedge clk_i);
      quiet = alert_minor ? 0 : quiet + 1;
    end
  endtask

  task automatic pulse_dbus_error(input logic integrity);
    dbus.rvalid    = 1'b1;
    dbus.err       = 1'b1;
    dbus.integrity = integrity;
    @(negedge clk_i);
    dbus = '0;
  endtask

  initial begin
    reset_i      = 1'b1;
    wbs_req      = '0;
    retire       = '0;
    dbus         = '0;
    dummy_en     = 1'b0;
    hint_en      = 1'b0;
    nmi_ack      = 1'b0;
    model_alerts = 0;
    rng          = 32'h67b0;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    // Exception filter, listed and unlisted causes mixed
    repeat (BURST_RETIRES) begin
      rng              = xorshift32(rng);
      pick             = int'(rng[7:5]) % 5;
      retire.valid     = rng[0] | rng[1];
      retire.exception = rng[2] | rng[3];
      retire.cause     = rng[4] ? alert_causes[pick] : rng[26:16];
      if (retire.valid && retire.exception && is_alert_cause(retire.cause)) begin
        model_alerts++;
      end
      @(negedge clk_i);
    end
    retire = '0;
    wait_alerts(model_alerts);
    wb_read(ADDR_STATUS, rdata);
    check_value("status after exception filter", rdata, {16'd0, 16'(model_alerts)});

    // Zero seed with generators running is a lockup
    for (int i = 0; i < LFSR_COUNT; i++) begin
      dummy_en = 1'b1;
      wb_write(ADDR_WIDTH'(i), 32'd0);
      dummy_en = 1'b0;
      model_alerts++;
      wait_alerts(model_alerts);
      wb_read(ADDR_LAST, rdata);
      check_value("last record after lockup", rdata, {14'd0, KIND_LOCKUP, 16'(i)});
      wb_read(ADDR_WIDTH'(i), rdata);
      check_value("LFSR after lockup", rdata, LFSR_RESET_VALUE);
    end
    // Silent reload with both enables low
    wb_write(ADDR_SEED0, 32'd0);
    wait_alerts(model_alerts);
    wb_read(ADDR_SEED0, rdata);
    check_value("LFSR after silent reload", rdata, LFSR_RESET_VALUE);

    // NMI path
    pulse_dbus_error(1'b1);
    assert (!nmip) else report_error("nmip set by an error with integrity");
    pulse_dbus_error(1'b0);
    assert (nmip) else report_error("nmip not set one cycle after a bus error");
    pulse_dbus_error(1'b0);
    assert (nmip) else report_error("nmip lost on a second bus error");
    wait_alerts(model_alerts);
    nmi_ack = 1'b1;
    @(negedge clk_i);
    nmi_ack = 1'b0;
    assert (!nmip) else report_error("nmip still set after the NMI acknowledge");
    model_alerts++;
    wait_alerts(model_alerts);
    wb_read(ADDR_LAST, rdata);
    check_value("last record after NMI", rdata, {14'd0, KIND_NMI, 16'd0});

    // Overflow, exceptions every cycle plus lockups every second cycle
    wb_read(ADDR_STATUS, rdata);
    count_before = int'(rdata[15:0]);
    burst_events = BURST_WRITES + BURST_RETIRES;
    hint_en = 1'b1;
    fork
      begin
        for (int j = 0; j < BURST_WRITES; j++) begin
          wb_write(ADDR_WIDTH'(j % LFSR_COUNT), 32'd0);
        end
      end
      begin
        repeat (BURST_RETIRES) begin
          retire.valid     = 1'b1;
          retire.exception = 1'b1;
          retire.cause     = 11'd5;
          @(negedge clk_i);
        end
        retire = '0;
      end
    join
    hint_en = 1'b0;
    wait_quiet();
    wb_read(ADDR_STATUS, rdata);
    assert (rdata[16]) else report_error("overflow flag not set after the burst");
    assert (int'(rdata[15:0]) - count_before <= burst_events)
      else report_error("more alerts counted than events in the burst");
    check_value("count against alert pulses", 32'(rdata[15:0]), 32'(seen_alerts));
    model_alerts = seen_alerts;
    wb_write(ADDR_STATUS, 32'd0);
    wb_read(ADDR_STATUS, rdata);
    check_value("status after overflow clear", rdata, {16'd0, 16'(model_alerts)});

    // Register port, unused addresses and plain seed writes
    wb_write(3'd5, 32'hdead_beef);
    for (int a = 5; a < 8; a++) begin
      wb_read(ADDR_WIDTH'(a), rdata);
      check_value("unused address", rdata, 32'd0);
    end
    for (int i = 0; i < LFSR_COUNT; i++) begin
      rng      = xorshift32(rng);
      seeds[i] = rng | 32'd1;
      wb_write(ADDR_WIDTH'(i), seeds[i]);
    end
    for (int i = 0; i < LFSR_COUNT; i++) begin
      wb_read(ADDR_WIDTH'(i), rdata);
      check_value("seed readback", rdata, seeds[i]);
    end

    wait_alerts(model_alerts);
    wb_read(ADDR_STATUS, rdata);
    check_value("final status", rdata, {16'd0, 16'(model_alerts)});
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- design/xsecure_alerts_top.sv
`timescale 1ns/1ps
// ----------------------------------------------------------
// Security alert subsystem top
// LFSR bank and fault classifier feed the queue, reporter
// drains it, register slave exposes seeds and status
// ----------------------------------------------------------
module xsecure_alerts_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  alert_types_pkg::wbs_req_t   wbs_req_i,
  output alert_types_pkg::wbs_rsp_t   wbs_rsp_o,
  input  alert_types_pkg::wb_retire_t retire_i,
  input  alert_types_pkg::dbus_resp_t dbus_i,
  input  logic                        dummy_en_i,
  input  logic                        hint_en_i,
  input  logic                        nmi_ack_i,
  output logic                        alert_minor_o,
  output logic                        nmip_o
);
  import alert_cfg_pkg::*;
  import alert_types_pkg::*;

  // Producers to queue
  logic         lockup_valid;
  alert_event_t lockup_event;
  logic         fault_valid;
  alert_event_t fault_event;

  // Queue to reporter
  logic         not_empty;
  alert_event_t head;
  logic         pop;

  // Register side
  seed_write_t            seed;
  lfsr_state_t            lfsr_state;
  logic                   overflow;
  logic                   overflow_clr;
  logic [COUNT_WIDTH-1:0] alert_count;
  alert_event_t           last_event;

  lfsr_bank i_lfsr_bank (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dummy_en_i     (dummy_en_i),
    .hint_en_i      (hint_en_i),
    .seed_i         (seed),
    .lfsr_state_o   (lfsr_state),
    .lockup_valid_o (lockup_valid),
    .lockup_event_o (lockup_event)
  );

  fault_classifier i_fault_classifier (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .retire_i      (retire_i),
    .dbus_i        (dbus_i),
    .nmi_ack_i     (nmi_ack_i),
    .nmip_o        (nmip_o),
    .fault_valid_o (fault_valid),
    .fault_event_o (fault_event)
  );

  alert_queue i_alert_queue (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lockup_valid_i (lockup_valid),
    .lockup_event_i (lockup_event),
    .fault_valid_i  (fault_valid),
    .fault_event_i  (fault_event),
    .pop_i          (pop),
    .not_empty_o    (not_empty),
    .head_o         (head),
    .overflow_o     (overflow),
    .overflow_clr_i (overflow_clr)
  );

  alert_reporter i_alert_reporter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .not_empty_i   (not_empty),
    .head_i        (head),
    .pop_o         (pop),
    .alert_minor_o (alert_minor_o),
    .alert_count_o (alert_count),
    .last_event_o  (last_event)
  );

  alert_csr i_alert_csr (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wbs_req_i      (wbs_req_i),
    .wbs_rsp_o      (wbs_rsp_o),
    .lfsr_state_i   (lfsr_state),
    .alert_count_i  (alert_count),
    .overflow_i     (overflow),
    .last_event_i   (last_event),
    .seed_o         (seed),
    .overflow_clr_o (overflow_clr)
  );

endmodule

//--- design/alert_csr.sv
`timescale 1ns/1ps
// ----------------------------------------------------------
// Alert register slave, Wishbone classic
// Seed writes, status and last-record reads, one-cycle ack
// ----------------------------------------------------------
module alert_csr (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  alert_types_pkg::wbs_req_t             wbs_req_i,
  output alert_types_pkg::wbs_rsp_t             wbs_rsp_o,
  input  alert_types_pkg::lfsr_state_t          lfsr_state_i,
  input  logic [alert_cfg_pkg::COUNT_WIDTH-1:0] alert_count_i,
  input  logic                                  overflow_i,
  input  alert_types_pkg::alert_event_t         last_event_i,
  output alert_types_pkg::seed_write_t          seed_o,
  output logic                                  overflow_clr_o
);
  import alert_cfg_pkg::*;

  logic                     ack_q;
  logic                     req_fire;
  logic                     wr_fire;
  logic [WB_DATA_WIDTH-1:0] rdata_d;
  logic [WB_DATA_WIDTH-1:0] rdata_q;

  // Sample once per access, ack blocks a second sample
  assign req_fire = wbs_req_i.cyc && wbs_req_i.stb && !ack_q;
  assign wr_fire  = req_fire && wbs_req_i.we;

  // Write strobes, one cycle wide
  always_comb begin
    seed_o.data  = wbs_req_i.dat;
    seed_o.we    = '0;
    seed_o.we[0] = wr_fire && (wbs_req_i.adr == ADDR_SEED0);
    seed_o.we[1] = wr_fire && (wbs_req_i.adr == ADDR_SEED1);
    seed_o.we[2] = wr_fire && (wbs_req_i.adr == ADDR_SEED2);
  end

  // Any write to status clears overflow
  assign overflow_clr_o = wr_fire && (wbs_req_i.adr == ADDR_STATUS);

  // Read mux
  always_comb begin
    case (wbs_req_i.adr)
      ADDR_SEED0:  rdata_d = lfsr_state_i[0];
      ADDR_SEED1:  rdata_d = lfsr_state_i[1];
      ADDR_SEED2:  rdata_d = lfsr_state_i[2];
      // Overflow in bit 16 above the count
      ADDR_STATUS: rdata_d = WB_DATA_WIDTH'({overflow_i, alert_count_i});
      ADDR_LAST:   rdata_d = WB_DATA_WIDTH'(last_event_i);
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_fire;
    end
  end

  // Held for the ack cycle
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rdata_q <= rdata_d;
    end
  end

  assign wbs_rsp_o.ack = ack_q;
  assign wbs_rsp_o.dat = rdata_q;

endmodule

//--- design/alert_reporter.sv
`timescale 1ns/1ps
// ----------------------------------------------------------
// Alert reporter
// Drains the queue one event per cycle into minor alert
// pulses, counts them and keeps the last record
// ----------------------------------------------------------
module alert_reporter (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  not_empty_i,
  input  alert_types_pkg::alert_event_t         head_i,
  output logic                                  pop_o,
  output logic                                  alert_minor_o,
  output logic [alert_cfg_pkg::COUNT_WIDTH-1:0] alert_count_o,
  output alert_types_pkg::alert_event_t         last_event_o
);
  import alert_cfg_pkg::*;

  // Never stalls, take the head whenever present
  assign pop_o = not_empty_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alert_minor_o <= 1'b0;
      alert_count_o <= '0;
      last_event_o  <= '0;
    end else begin
      // One alert cycle per popped event
      alert_minor_o <= pop_o;
      if (pop_o) begin
        last_event_o <= head_i;
        // Saturate at all ones
        if (alert_count_o != '1) begin
          alert_count_o <= alert_count_o + COUNT_WIDTH'(1);
        end
      end
    end
  end

endmodule

//--- design/alert_queue.sv
`timescale 1ns/1ps
// ----------------------------------------------------------
// Alert event queue
// Circular buffer, two writes and one read per cycle, with a
// sticky overflow flag for dropped events
// ----------------------------------------------------------
module alert_queue (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          lockup_valid_i,
  input  alert_types_pkg::alert_event_t lockup_event_i,
  input  logic                          fault_valid_i,
  input  alert_types_pkg::alert_event_t fault_event_i,
  input  logic                          pop_i,
  output logic                          not_empty_o,
  output alert_types_pkg::alert_event_t head_o,
  output logic                          overflow_o,
  input  logic                          overflow_clr_i
);
  import alert_cfg_pkg::*;
  import alert_types_pkg::*;

  alert_event_t         mem_q [QUEUE_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_q;
  logic [PTR_WIDTH-1:0] rd_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;
  logic [CNT_WIDTH-1:0] free_slots;
  logic                 wr_lock;
  logic                 wr_fault;
  logic                 drop;
  logic                 pop_ok;
  logic [1:0]           n_wr;

  // Space is judged before this cycle's pop
  assign free_slots = CNT_WIDTH'(QUEUE_DEPTH) - count_q;

  // Lockup takes the first free slot
  assign wr_lock  = lockup_valid_i && (free_slots != '0);
  assign wr_fault = fault_valid_i && (free_slots > CNT_WIDTH'(wr_lock));
  assign drop     = (lockup_valid_i && !wr_lock) || (fault_valid_i && !wr_fault);
  assign n_wr     = 2'(wr_lock) + 2'(wr_fault);

  assign not_empty_o = (count_q != '0);
  assign pop_ok      = pop_i && not_empty_o;
  assign head_o      = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_WIDTH'(n_wr);
      rd_ptr_q <= rd_ptr_q + PTR_WIDTH'(pop_ok);
      count_q  <= count_q + CNT_WIDTH'(n_wr) - CNT_WIDTH'(pop_ok);
      // Set beats clear
      if (drop) begin
        overflow_o <= 1'b1;
      end else if (overflow_clr_i) begin
        overflow_o <= 1'b0;
      end
    end
  end

  // Storage, fault lands behind lockup when both write
  always_ff @(posedge clk_i) begin
    if (wr_lock) begin
      mem_q[wr_ptr_q] <= lockup_event_i;
    end
    if (wr_fault) begin
      mem_q[wr_ptr_q + PTR_WIDTH'(wr_lock)] <= fault_event_i;
    end
  end

endmodule

//--- design/fault_classifier.sv
`timescale 1ns/1ps
// ----------------------------------------------------------
// Fault classifier
// Flags alert-worthy exceptions at writeback and tracks the
// NMI raised by data bus errors without integrity
// ----------------------------------------------------------
module fault_classifier (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  alert_types_pkg::wb_retire_t   retire_i,
  input  alert_types_pkg::dbus_resp_t   dbus_i,
  input  logic                          nmi_ack_i,
  output logic                          nmip_o,
  output logic                          fault_valid_o,
  output alert_types_pkg::alert_event_t fault_event_o
);
  import alert_cfg_pkg::*;
  import alert_types_pkg::*;

  logic         exc_hit;
  logic         bus_fault;
  logic         nmi_fire;
  logic         nmi_req;
  logic         nmi_pend_q;
  alert_event_t next_event;

  // Retiring exception with one of the five listed causes
  assign exc_hit = retire_i.valid && retire_i.exception &&
                   (retire_i.cause inside {CAUSE_INSTR_ACCESS, CAUSE_ILLEGAL,
                                           CAUSE_LOAD_ACCESS, CAUSE_STORE_ACCESS,
                                           CAUSE_INSTR_BUS});

  // New bus error only counts with no NMI outstanding
  assign bus_fault = dbus_i.rvalid && dbus_i.err && !dbus_i.integrity && !nmip_o;

  // Core entered the NMI handler
  assign nmi_fire = nmip_o && nmi_ack_i;
  assign nmi_req  = nmi_fire || nmi_pend_q;

  // Exception goes first on a collision
  always_comb begin
    next_event = '0;
    if (exc_hit) begin
      next_event.kind           = KIND_EXCEPTION;
      next_event.info.exc.cause = retire_i.cause;
    end else begin
      next_event.kind = KIND_NMI;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      nmip_o        <= 1'b0;
      nmi_pend_q    <= 1'b0;
      fault_valid_o <= 1'b0;
    end else begin
      if (nmi_fire) begin
        nmip_o <= 1'b0;
      end else if (bus_fault) begin
        nmip_o <= 1'b1;
      end
      fault_valid_o <= exc_hit || nmi_req;
      // NMI event held back one cycle
      nmi_pend_q    <= exc_hit && nmi_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exc_hit || nmi_req) begin
      fault_event_o <= next_event;
    end
  end

endmodule

//--- lfsr_bank/lfsr_bank.sv
`timescale 1ns/1ps
// ----------------------------------------------------------
// LFSR bank for dummy and hint instruction insertion
// Three Galois LFSRs with lockup detection and reload
// ----------------------------------------------------------
module lfsr_bank (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          dummy_en_i,
  input  logic                          hint_en_i,
  input  alert_types_pkg::seed_write_t  seed_i,
  output alert_types_pkg::lfsr_state_t  lfsr_state_o,
  output logic                          lockup_valid_o,
  output alert_types_pkg::alert_event_t lockup_event_o
);
  import alert_cfg_pkg::*;
  import alert_types_pkg::*;

  lfsr_state_t               state_q;
  lfsr_state_t               state_d;
  logic [LFSR_COUNT-1:0]     lockup;
  logic [LFSR_IDX_WIDTH-1:0] lock_idx;
  logic                      step_en;
  alert_event_t              lock_event;

  // Right shift, feedback from bit 0
  function automatic logic [LFSR_WIDTH-1:0] galois_step(
    input logic [LFSR_WIDTH-1:0] s
  );
    logic [LFSR_WIDTH-1:0] shifted;
    shifted = {1'b0, s[LFSR_WIDTH-1:1]};
    return s[0] ? (shifted ^ LFSR_POLY) : shifted;
  endfunction

  // Either insertion feature keeps the generators running
  assign step_en = dummy_en_i || hint_en_i;

  always_comb begin
    lockup = '0;
    for (int i = 0; i < LFSR_COUNT; i++) begin
      // Seed write has priority over stepping
      if (seed_i.we[i]) begin
        state_d[i] = seed_i.data;
      end else if (step_en) begin
        state_d[i] = galois_step(state_q[i]);
      end else begin
        state_d[i] = state_q[i];
      end
      // All-zero state never leaves zero
      if (state_d[i] == '0) begin
        state_d[i] = LFSR_RESET_VALUE;
        // Silent reload while disabled
        lockup[i]  = step_en;
      end
    end
  end

  // Lowest locked index wins
  always_comb begin
    lock_idx = '0;
    for (int i = LFSR_COUNT - 1; i >= 0; i--) begin
      if (lockup[i]) begin
        lock_idx = LFSR_IDX_WIDTH'(i);
      end
    end
  end

  always_comb begin
    lock_event                   = '0;
    lock_event.kind              = KIND_LOCKUP;
    lock_event.info.lockup.index = lock_idx;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q        <= {LFSR_COUNT{LFSR_RESET_VALUE}};
      lockup_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      lockup_valid_o <= |lockup;
    end
  end

  // Record only, qualified by lockup_valid_o
  always_ff @(posedge clk_i) begin
    if (|lockup) begin
      lockup_event_o <= lock_event;
    end
  end

  assign lfsr_state_o = state_q;

endmodule

//--- common/alert_types_pkg.sv
// ----------------------------------------------------------
// Alert subsystem types
// Event records, retire and bus inputs, register port
// ----------------------------------------------------------
package alert_types_pkg;

  // Source of a queued alert
  typedef enum logic [1:0] {
    KIND_LOCKUP    = 2'd0,
    KIND_EXCEPTION = 2'd1,
    KIND_NMI       = 2'd2
  } alert_kind_e;

  // Exception view: cause in the low bits
  typedef struct packed {
    logic [alert_cfg_pkg::INFO_WIDTH-alert_cfg_pkg::CAUSE_WIDTH-1:0] pad;
    logic [alert_cfg_pkg::CAUSE_WIDTH-1:0]                           cause;
  } exc_info_t;

  // Lockup view: index of the locked LFSR
  typedef struct packed {
    logic [alert_cfg_pkg::INFO_WIDTH-alert_cfg_pkg::LFSR_IDX_WIDTH-1:0] pad;
    logic [alert_cfg_pkg::LFSR_IDX_WIDTH-1:0]                           index;
  } lockup_info_t;

  // One info word, decoded by kind; all zero for NMI records
  typedef union packed {
    exc_info_t    exc;
    lockup_info_t lockup;
  } alert_info_u;

  typedef struct packed {
    alert_kind_e kind;
    alert_info_u info;
  } alert_event_t;

  // Writeback stage retirement
  typedef struct packed {
    logic                                  valid;
    logic                                  exception;
    logic [alert_cfg_pkg::CAUSE_WIDTH-1:0] cause;
  } wb_retire_t;

  // Data bus response
  typedef struct packed {
    logic rvalid;
    logic err;
    logic integrity;
  } dbus_resp_t;

  typedef struct packed {
    logic [alert_cfg_pkg::LFSR_COUNT-1:0] we;
    logic [alert_cfg_pkg::LFSR_WIDTH-1:0] data;
  } seed_write_t;

  typedef logic [alert_cfg_pkg::LFSR_COUNT-1:0][alert_cfg_pkg::LFSR_WIDTH-1:0] lfsr_state_t;

  // Wishbone classic request and response
  typedef struct packed {
    logic                                    cyc;
    logic                                    stb;
    logic                                    we;
    logic [alert_cfg_pkg::ADDR_WIDTH-1:0]    adr;
    logic [alert_cfg_pkg::WB_DATA_WIDTH-1:0] dat;
  } wbs_req_t;

  typedef struct packed {
    logic                                    ack;
    logic [alert_cfg_pkg::WB_DATA_WIDTH-1:0] dat;
  } wbs_rsp_t;

endpackage

//--- common/alert_cfg_pkg.sv
// ----------------------------------------------------------
// Alert subsystem configuration
// Widths, alert-worthy cause codes, queue depth, register map
// ----------------------------------------------------------
package alert_cfg_pkg;

  // LFSR bank
  localparam int LFSR_COUNT     = 3;
  localparam int LFSR_WIDTH     = 32;
  localparam int LFSR_IDX_WIDTH = $clog2(LFSR_COUNT);
  // Reload value after a lockup, must be nonzero
  localparam logic [LFSR_WIDTH-1:0] LFSR_RESET_VALUE = 32'h5a3c_96e1;
  // Taps 32, 22, 2, 1 (maximal length)
  localparam logic [LFSR_WIDTH-1:0] LFSR_POLY        = 32'h8020_0003;

  // Exception causes that raise the minor alert
  localparam int CAUSE_WIDTH = 11;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_INSTR_ACCESS = 11'd1;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_ILLEGAL      = 11'd2;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_LOAD_ACCESS  = 11'd5;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_STORE_ACCESS = 11'd7;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_INSTR_BUS    = 11'd24;

  // Alert record payload
  localparam int INFO_WIDTH = 16;

  // Event queue and alert counter
  localparam int QUEUE_DEPTH = 8;
  localparam int PTR_WIDTH   = $clog2(QUEUE_DEPTH);
  localparam int CNT_WIDTH   = PTR_WIDTH + 1;
  localparam int COUNT_WIDTH = 16;

  // Wishbone register map, word addresses
  localparam int WB_DATA_WIDTH = 32;
  localparam int ADDR_WIDTH    = 3;
  localparam logic [ADDR_WIDTH-1:0] ADDR_SEED0  = 3'd0;
  localparam logic [ADDR_WIDTH-1:0] ADDR_SEED1  = 3'd1;
  localparam logic [ADDR_WIDTH-1:0] ADDR_SEED2  = 3'd2;
  localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 3'd3;
  localparam logic [ADDR_WIDTH-1:0] ADDR_LAST   = 3'd4;

endpackage
